/* common/ide_pkg.sv */
`default_nettype none

package ide_pkg;

	// IDE data bus width
	localparam int IDE_DW = 16;

	// IDE register address width, covers one chip select bank
	localparam int IDE_AW = 3;

	// one-hot phase count of a single PIO access
	// t1, two cycles of t2, and recovery
	localparam int PIO_PHASES = 5;

	// z80 side widths
	localparam int Z80_DW = 8;
	localparam int PORT_W = 5;

	// dma block length field, 0 stands for a full 256-word block
	localparam int DMA_LW = 8;

	// the 16-bit data register sits at CS0 address 0
	localparam logic [IDE_AW-1:0] IDE_REG_DATA = '0;

	// z80 port map
	// 0..7 are CS0 regs, 8..15 are CS1 regs
	// 16 is the high byte latch for the data register
	localparam logic [PORT_W-1:0] PORT_HI = 5'd16;

	// one requested IDE access, 22 bits
	typedef struct packed
	{
		logic [IDE_DW-1:0] wdata;
		logic [IDE_AW-1:0] addr;
		logic              cs0_n;
		logic              cs1_n;
		// 1 = read from drive
		logic              rnw;
	} ide_cmd_t;

endpackage

`default_nettype wire

/* ide/ide_pio.sv */
`timescale 1ns/1ps
`default_nettype none

// PIO-4 access sequencer at 28 MHz
// cycle 0   accept, command latched
// cycle 1   cs, address and dir on the pins (t1)
// cycle 2-3 rd_n or wr_n low (t2)
// cycle 4   strobe and cs released
// cycle 5   rdy_stb
// cycle 6   rdy again
module ide_pio
(
	input  wire                                 clk,
	input  wire                                 reset,

	// requesters, dma has priority
	input  wire                                 dma_req,
	input  wire ide_pkg::ide_cmd_t              dma_cmd,
	input  wire                                 z80_req,
	input  wire ide_pkg::ide_cmd_t              z80_cmd,

	output logic                                rdy,
	output logic                                rdy_stb,
	output logic                                dma_owner,
	output logic [ide_pkg::IDE_DW-1:0]          rdata,

	// IDE pins
	input  wire  [ide_pkg::IDE_DW-1:0]          ide_din,
	output logic [ide_pkg::IDE_DW-1:0]          ide_wdata,
	output logic [ide_pkg::IDE_AW-1:0]          ide_a,
	output logic                                ide_dir,
	output logic                                ide_cs0_n,
	output logic                                ide_cs1_n,
	output logic                                ide_rd_n,
	output logic                                ide_wr_n
);

	logic [ide_pkg::PIO_PHASES-1:0] st;
	ide_pkg::ide_cmd_t              sel_cmd;
	ide_pkg::ide_cmd_t              cmd_q;
	logic                           go;

	// dma command wins when both ask
	assign sel_cmd = dma_req ? dma_cmd : z80_cmd;

	// idle when no phase bit is in flight
	assign rdy = ~|st;
	assign go = rdy & (dma_req | z80_req);

	// last phase ends the access
	assign rdy_stb = st[ide_pkg::PIO_PHASES-1];

	// address and write data come from the latched command
	// so they hold still for the whole access
	assign ide_a = cmd_q.addr;
	assign ide_wdata = cmd_q.wdata;

	// phase shifter, a single bit walks through
	always_ff @(posedge clk)
	begin
		if (reset)
			st <= '0;
		else
			st <= {st[ide_pkg::PIO_PHASES-2:0], go};
	end

	// command capture at acceptance
	always_ff @(posedge clk)
	begin
		if (go)
			cmd_q <= sel_cmd;
	end

	// owner of the access in flight
	always_ff @(posedge clk)
	begin
		if (reset)
			dma_owner <= 1'b0;
		else if (go)
			dma_owner <= dma_req;
	end

	// pin control from phases
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ide_dir   <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
			ide_rd_n  <= 1'b1;
			ide_wr_n  <= 1'b1;
		end
		else if (go)
		begin
			// t1 starts, cs and direction
			ide_dir   <= sel_cmd.rnw;
			ide_cs0_n <= sel_cmd.cs0_n;
			ide_cs1_n <= sel_cmd.cs1_n;
		end
		else if (st[0])
		begin
			// t2 starts, only one strobe goes low
			ide_rd_n  <= ~cmd_q.rnw;
			ide_wr_n  <= cmd_q.rnw;
		end
		else if (st[2])
		begin
			// end of t2, release everything
			ide_dir   <= 1'b1;
			ide_cs0_n <= 1'b1;
			ide_cs1_n <= 1'b1;
			ide_rd_n  <= 1'b1;
			ide_wr_n  <= 1'b1;
		end
	end

	// read data sampled at the end of the second t2 cycle
	// while rd_n is still low
	always_ff @(posedge clk)
	begin
		if (st[2] && cmd_q.rnw)
			rdata <= ide_din;
	end

endmodule

`default_nettype wire

/* src/ide_dma.sv */
`timescale 1ns/1ps
`default_nettype none

// block mover between the IDE data register and an outside word buffer
// one data register access per word
module ide_dma
(
	input  wire                                 clk,
	input  wire                                 reset,

	// control
	input  wire                                 dma_start,
	input  wire                                 dma_rnw,
	input  wire  [ide_pkg::DMA_LW-1:0]          dma_len,
	output logic                                dma_busy,
	output logic                                dma_done,

	// word buffer
	input  wire  [ide_pkg::IDE_DW-1:0]          buf_rdata,
	output logic                                buf_rstb,
	output logic                                buf_wstb,
	output logic [ide_pkg::IDE_DW-1:0]          buf_wdata,

	// sequencer side
	input  wire                                 rdy_stb,
	input  wire                                 dma_owner,
	input  wire  [ide_pkg::IDE_DW-1:0]          rdata,
	output logic                                dma_req,
	output ide_pkg::ide_cmd_t                   dma_cmd
);

	// one extra bit so a zero length loads as 256
	logic [ide_pkg::DMA_LW:0] cnt;
	logic                     rnw_q;
	logic                     own_done;
	logic                     start_ok;
	logic                     last;

	assign start_ok = dma_start & ~dma_busy;
	assign own_done = rdy_stb & dma_owner;
	assign last = (cnt == 1);

	// always the CS0 data register
	// write data straight from the buffer head
	always_comb
	begin
		dma_cmd.wdata = buf_rdata;
		dma_cmd.addr  = ide_pkg::IDE_REG_DATA;
		dma_cmd.cs0_n = 1'b0;
		dma_cmd.cs1_n = 1'b1;
		dma_cmd.rnw   = rnw_q;
	end

	// buffer strobes ride on our own completions
	assign buf_rstb = own_done & ~rnw_q;
	assign buf_wstb = own_done & rnw_q;
	assign buf_wdata = rdata;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dma_busy <= 1'b0;
			dma_done <= 1'b0;
			dma_req  <= 1'b0;
			cnt      <= '0;
		end
		else
		begin
			dma_done <= 1'b0;
			if (start_ok)
			begin
				dma_busy <= 1'b1;
				dma_req  <= 1'b1;
				cnt      <= {dma_len == '0, dma_len};
			end
			else if (own_done)
			begin
				// drop for a cycle so a waiting z80 access gets a slot
				dma_req <= 1'b0;
				cnt     <= cnt - 1'b1;
				if (last)
				begin
					dma_busy <= 1'b0;
					dma_done <= 1'b1;
				end
			end
			else if (dma_busy && !dma_req)
				dma_req <= 1'b1;
		end
	end

	// direction of the block
	always_ff @(posedge clk)
	begin
		if (start_ok)
			rnw_q <= dma_rnw;
	end

endmodule

`default_nettype wire

/* src/ide_top.sv */
`timescale 1ns/1ps
`default_nettype none

// IDE host controller, z80 ports plus dma mover on one PIO sequencer
module ide_top
(
	input  wire                                 clk,
	input  wire                                 reset,

	// z80 bus
	input  wire                                 io_wr,
	input  wire                                 io_rd,
	input  wire  [ide_pkg::PORT_W-1:0]          port,
	input  wire  [ide_pkg::Z80_DW-1:0]          din,
	output logic [ide_pkg::Z80_DW-1:0]          dout,
	output logic                                z80_wait,

	// dma control and buffer
	input  wire                                 dma_start,
	input  wire                                 dma_rnw,
	input  wire  [ide_pkg::DMA_LW-1:0]          dma_len,
	output logic                                dma_busy,
	output logic                                dma_done,
	input  wire  [ide_pkg::IDE_DW-1:0]          buf_rdata,
	output logic                                buf_rstb,
	output logic [ide_pkg::IDE_DW-1:0]          buf_wdata,
	output logic                                buf_wstb,

	// IDE pins
	inout  wire  [ide_pkg::IDE_DW-1:0]          ide_d,
	output logic [ide_pkg::IDE_AW-1:0]          ide_a,
	output logic                                ide_cs0_n,
	output logic                                ide_cs1_n,
	output logic                                ide_rd_n,
	output logic                                ide_wr_n
);

	ide_pkg::ide_cmd_t          dma_cmd;
	ide_pkg::ide_cmd_t          z80_cmd;
	logic                       dma_req;
	logic                       z80_req;
	logic                       rdy_stb;
	logic                       dma_owner;
	logic [ide_pkg::IDE_DW-1:0] rdata;
	logic [ide_pkg::IDE_DW-1:0] ide_wdata;
	logic                       ide_dir;

	// pins driven only on writes
	assign ide_d = ide_dir ? {ide_pkg::IDE_DW{1'bz}} : ide_wdata;

	z80_ide_port port0
	(
		.clk       (clk),
		.reset     (reset),
		.io_wr     (io_wr),
		.io_rd     (io_rd),
		.port      (port),
		.din       (din),
		.dout      (dout),
		.z80_wait  (z80_wait),
		.rdy_stb   (rdy_stb),
		.dma_owner (dma_owner),
		.rdata     (rdata),
		.z80_req   (z80_req),
		.z80_cmd   (z80_cmd)
	);

	ide_dma dma0
	(
		.clk       (clk),
		.reset     (reset),
		.dma_start (dma_start),
		.dma_rnw   (dma_rnw),
		.dma_len   (dma_len),
		.dma_busy  (dma_busy),
		.dma_done  (dma_done),
		.buf_rdata (buf_rdata),
		.buf_rstb  (buf_rstb),
		.buf_wstb  (buf_wstb),
		.buf_wdata (buf_wdata),
		.rdy_stb   (rdy_stb),
		.dma_owner (dma_owner),
		.rdata     (rdata),
		.dma_req   (dma_req),
		.dma_cmd   (dma_cmd)
	);

	// requesters hold their lines and wait for rdy_stb
	// so rdy itself is not needed up here
	ide_pio pio0
	(
		.clk       (clk),
		.reset     (reset),
		.dma_req   (dma_req),
		.dma_cmd   (dma_cmd),
		.z80_req   (z80_req),
		.z80_cmd   (z80_cmd),
		.rdy       (),
		.rdy_stb   (rdy_stb),
		.dma_owner (dma_owner),
		.rdata     (rdata),
		.ide_din   (ide_d),
		.ide_wdata (ide_wdata),
		.ide_a     (ide_a),
		.ide_dir   (ide_dir),
		.ide_cs0_n (ide_cs0_n),
		.ide_cs1_n (ide_cs1_n),
		.ide_rd_n  (ide_rd_n),
		.ide_wr_n  (ide_wr_n)
	);

endmodule

`default_nettype wire

/* src/z80_ide_port.sv */
`timescale 1ns/1ps
`default_nettype none

// z80 I/O ports onto the IDE sequencer
// the 16-bit data register is reached through the PORT_HI latch
module z80_ide_port
(
	input  wire                                 clk,
	input  wire                                 reset,

	// z80 I/O cycle, one-cycle strobes
	input  wire                                 io_wr,
	input  wire                                 io_rd,
	input  wire  [ide_pkg::PORT_W-1:0]          port,
	input  wire  [ide_pkg::Z80_DW-1:0]          din,
	output logic [ide_pkg::Z80_DW-1:0]          dout,
	output logic                                z80_wait,

	// sequencer side
	input  wire                                 rdy_stb,
	input  wire                                 dma_owner,
	input  wire  [ide_pkg::IDE_DW-1:0]          rdata,
	output logic                                z80_req,
	output ide_pkg::ide_cmd_t                   z80_cmd
);

	logic [ide_pkg::Z80_DW-1:0] hi_q;
	logic                       io_stb;
	logic                       is_ide;
	logic                       is_hi;
	logic                       acc_done;
	logic                       data_rd;

	// strobes during a pending access are dropped
	assign io_stb = (io_wr | io_rd) & ~z80_wait;

	// ports 0..15 map to IDE registers
	// ports above PORT_HI decode to nothing
	assign is_ide = ~port[ide_pkg::PORT_W-1];
	assign is_hi = (port == ide_pkg::PORT_HI);

	// our own access finished, not a dma one
	assign acc_done = rdy_stb & ~dma_owner & z80_req;

	// read of the CS0 data register fills the high latch
	assign data_rd = z80_cmd.rnw & ~z80_cmd.cs0_n &
		(z80_cmd.addr == ide_pkg::IDE_REG_DATA);

	// request and wait
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z80_req  <= 1'b0;
			z80_wait <= 1'b0;
		end
		else if (acc_done)
		begin
			z80_req  <= 1'b0;
			z80_wait <= 1'b0;
		end
		else if (io_stb && is_ide)
		begin
			z80_req  <= 1'b1;
			z80_wait <= 1'b1;
		end
	end

	// command, latch and read data
	always_ff @(posedge clk)
	begin
		if (io_stb)
		begin
			if (is_ide)
			begin
				// port bit 3 picks the chip select bank
				z80_cmd.wdata <= {hi_q, din};
				z80_cmd.addr  <= port[ide_pkg::IDE_AW-1:0];
				z80_cmd.cs0_n <= port[ide_pkg::IDE_AW];
				z80_cmd.cs1_n <= ~port[ide_pkg::IDE_AW];
				z80_cmd.rnw   <= ~io_wr;
			end
			else if (is_hi)
			begin
				// latch access, no IDE cycle
				if (io_wr)
					hi_q <= din;
				else
					dout <= hi_q;
			end
		end

		if (acc_done && z80_cmd.rnw)
		begin
			dout <= rdata[ide_pkg::Z80_DW-1:0];
			if (data_rd)
				hi_q <= rdata[ide_pkg::IDE_DW-1:ide_pkg::Z80_DW];
		end
	end

endmodule

`default_nettype wire

/* verification/hdd_model.sv */
`timescale 1ns/1ps
`default_nettype none

// behavioral IDE drive
// 8 CS0 and 8 CS1 registers, CS0 reg 0 is a word buffer
module hdd_model
(
	input  wire                                 clk,
	input  wire                                 reset,
	inout  wire  [ide_pkg::IDE_DW-1:0]          ide_d,
	input  wire  [ide_pkg::IDE_AW-1:0]          ide_a,
	input  wire                                 ide_cs0_n,
	input  wire                                 ide_cs1_n,
	input  wire                                 ide_rd_n,
	input  wire                                 ide_wr_n
);

	logic [ide_pkg::IDE_DW-1:0] regs [16];
	logic [ide_pkg::IDE_DW-1:0] words [512];
	logic [8:0]                 wptr;
	logic [8:0]                 rptr;
	logic                       sel;
	logic                       is_data;
	logic                       data_rd;
	logic [3:0]                 idx;
	logic [ide_pkg::IDE_DW-1:0] rd_word;

	assign sel = ~ide_cs0_n | ~ide_cs1_n;
	assign is_data = ~ide_cs0_n & (ide_a == ide_pkg::IDE_REG_DATA);

	// upper index bit is the CS1 bank
	assign idx = {ide_cs0_n, ide_a};
	assign rd_word = is_data ? words[rptr] : regs[idx];

	// drive the bus only while read strobe is low
	assign ide_d = (sel && !ide_rd_n) ? rd_word : {ide_pkg::IDE_DW{1'bz}};

	initial
	begin
		for (int i = 0; i < 16; i++)
			regs[i] = 16'hd000 + 16'(i);
		for (int i = 0; i < 512; i++)
			words[i] = 16'ha000 ^ 16'(i);
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			wptr = '0;
			rptr = '0;
		end
	end

	// host data already sits on the pins when wr_n falls
	always @(negedge ide_wr_n)
	begin
		if (is_data)
		begin
			words[wptr] = ide_d;
			wptr = wptr + 1'b1;
		end
		else if (sel)
		begin
			regs[idx] = ide_d;
			// CS0 reg 7 rewinds the buffer
			if (!ide_cs0_n && ide_a == 3'd7)
			begin
				wptr = '0;
				rptr = '0;
			end
		end
	end

	// cs is gone by the time rd_n rises, so note the target here
	always @(negedge ide_rd_n)
		data_rd = is_data;

	// next word once the read strobe ends
	always @(posedge ide_rd_n)
	begin
		if (data_rd === 1'b1)
			rptr = rptr + 1'b1;
	end

endmodule

`default_nettype wire

/* verification/ide_chk.sv */
`timescale 1ns/1ps
`default_nettype none

// IDE pin protocol checks bound into ide_top
module ide_chk
(
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [ide_pkg::IDE_AW-1:0]          ide_a,
	input  wire                                 ide_cs0_n,
	input  wire                                 ide_cs1_n,
	input  wire                                 ide_rd_n,
	input  wire                                 ide_wr_n
);

	logic strb;
	// running count of protocol violations
	int   fails = 0;

	// some strobe is active
	assign strb = ~ide_rd_n | ~ide_wr_n;

	// one direction at a time
	a_one_strobe: assert property (@(posedge clk) disable iff (reset)
		!(!ide_rd_n && !ide_wr_n))
		else
		begin
			$error("rd_n and wr_n low together");
			fails++;
		end

	// strobe needs a selected drive register
	a_strobe_cs: assert property (@(posedge clk) disable iff (reset)
		strb |-> (!ide_cs0_n || !ide_cs1_n))
		else
		begin
			$error("strobe low with both chip selects high");
			fails++;
		end

	// address settled before t2 and held through it
	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		strb |-> $stable(ide_a))
		else
		begin
			$error("ide_a moved during a strobe");
			fails++;
		end

endmodule

`default_nettype wire

/* verification/ide_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ide_tb;

	typedef enum logic [2:0] {Z80_WR, Z80_RD, DMA_WR, DMA_RD, CONC} kind_t;

	// one table row
	// dma rows use only the kind
	typedef struct packed
	{
		kind_t                      kind;
		logic [ide_pkg::PORT_W-1:0] port;
		logic [ide_pkg::Z80_DW-1:0] data;
		logic [ide_pkg::Z80_DW-1:0] want;
	} row_t;

	logic                       clk;
	logic                       reset;
	logic                       io_wr;
	logic                       io_rd;
	logic [ide_pkg::PORT_W-1:0] port;
	logic [ide_pkg::Z80_DW-1:0] din;
	logic                       dma_start;
	logic                       dma_rnw;
	logic [ide_pkg::DMA_LW-1:0] dma_len;
	wire  [ide_pkg::Z80_DW-1:0] dout;
	wire                        z80_wait;
	wire                        dma_busy;
	wire                        dma_done;
	wire  [ide_pkg::IDE_DW-1:0] buf_rdata;
	wire                        buf_rstb;
	wire  [ide_pkg::IDE_DW-1:0] buf_wdata;
	wire                        buf_wstb;
	wire  [ide_pkg::IDE_DW-1:0] ide_d;
	wire  [ide_pkg::IDE_AW-1:0] ide_a;
	wire                        ide_cs0_n;
	wire                        ide_cs1_n;
	wire                        ide_rd_n;
	wire                        ide_wr_n;

	// outside word buffer with its source and captured sides
	logic [ide_pkg::IDE_DW-1:0] src_words [256];
	logic [7:0]                 src_idx;
	logic [ide_pkg::IDE_DW-1:0] cap_q [$];
	int                         rstb_cnt;
	int                         done_cnt;
	int                         blk_len;
	int                         errors;
	int                         checks;
	row_t                       rows [$];

	ide_top dut0
	(
		.clk(clk), .reset(reset), .io_wr(io_wr), .io_rd(io_rd), .port(port), .din(din),
		.dout(dout), .z80_wait(z80_wait), .dma_start(dma_start), .dma_rnw(dma_rnw),
		.dma_len(dma_len), .dma_busy(dma_busy), .dma_done(dma_done),
		.buf_rdata(buf_rdata), .buf_rstb(buf_rstb), .buf_wdata(buf_wdata),
		.buf_wstb(buf_wstb), .ide_d(ide_d), .ide_a(ide_a), .ide_cs0_n(ide_cs0_n),
		.ide_cs1_n(ide_cs1_n), .ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n)
	);

	hdd_model hdd0
	(
		.clk(clk), .reset(reset), .ide_d(ide_d), .ide_a(ide_a), .ide_cs0_n(ide_cs0_n),
		.ide_cs1_n(ide_cs1_n), .ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n)
	);

	bind ide_top ide_chk chk0
	(
		.clk(clk), .reset(reset), .ide_a(ide_a), .ide_cs0_n(ide_cs0_n),
		.ide_cs1_n(ide_cs1_n), .ide_rd_n(ide_rd_n), .ide_wr_n(ide_wr_n)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// buffer head follows the read strobes
	assign buf_rdata = src_words[src_idx];

	// buffer side monitor at mid-cycle where strobes are settled
	always @(negedge clk)
	begin
		if (buf_wstb)
			cap_q.push_back(buf_wdata);
		if (buf_rstb)
		begin
			rstb_cnt++;
			src_idx = src_idx + 1'b1;
		end
		if (dma_done)
			done_cnt++;
	end

	function void add_row(kind_t k, logic [4:0] p, logic [7:0] d, logic [7:0] w);
		rows.push_back('{kind: k, port: p, data: d, want: w});
	endfunction

	task automatic check_dout(input logic [7:0] q, input logic [7:0] want);
		checks++;
		assert (q == want)
		else
		begin
			$display("** Error: dout = %h, expected %h", q, want);
			errors++;
		end
	endtask

	// one z80 I/O cycle leaving the read value in q
	task automatic z80_io(input logic wr, input logic [4:0] p, input logic [7:0] d,
		output logic [7:0] q, output logic ok);
		int n;
		@(posedge clk);
		io_wr <= wr;
		io_rd <= ~wr;
		port <= p;
		din <= d;
		@(posedge clk);
		io_wr <= 1'b0;
		io_rd <= 1'b0;
		n = 0;
		@(negedge clk);
		while (z80_wait && n < 200)
		begin
			@(negedge clk);
			n++;
		end
		ok = !z80_wait;
		q = dout;
		if (!ok)
		begin
			$display("z80 access on port %h timed out, z80_wait never dropped", p);
			errors++;
		end
	endtask

	// whole dma block plus its buffer side checks
	task automatic dma_block(input logic rnw, input int len);
		int n;
		int done0;
		@(posedge clk);
		cap_q.delete();
		rstb_cnt = 0;
		src_idx = '0;
		done0 = done_cnt;
		dma_start <= 1'b1;
		dma_rnw <= rnw;
		dma_len <= len[7:0];
		@(posedge clk);
		dma_start <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!dma_done && n < 8000)
		begin
			@(negedge clk);
			n++;
		end
		if (!dma_done)
		begin
			$display("dma block timed out, dma_done never pulsed");
			errors++;
		end
		repeat (3) @(posedge clk);
		checks += 3;
		assert (done_cnt - done0 == 1)
		else
		begin
			$display("** Error: dma_done count = %h, expected %h", done_cnt - done0, 1);
			errors++;
		end
		assert (cap_q.size() == (rnw ? len : 0))
		else
		begin
			$display("** Error: buf_wstb count = %h, expected %h", cap_q.size(), rnw ? len : 0);
			errors++;
		end
		assert (rstb_cnt == (rnw ? 0 : len))
		else
		begin
			$display("** Error: buf_rstb count = %h, expected %h", rstb_cnt, rnw ? 0 : len);
			errors++;
		end
		// words back in the order they went out
		for (int i = 0; i < cap_q.size() && i < len; i++)
		begin
			checks++;
			assert (cap_q[i] == src_words[i])
			else
			begin
				$display("** Error: buf_wdata = %h, expected %h", cap_q[i], src_words[i]);
				errors++;
			end
		end
	endtask

	initial
	begin
		row_t       r;
		logic [7:0] q;
		logic       ok;
		int         err0;
		void'($urandom(81639));
		for (int i = 0; i < 256; i++)
			src_words[i] = 16'($urandom);
		src_idx = '0;
		io_wr = 1'b0;
		io_rd = 1'b0;
		port = '0;
		din = '0;
		dma_start = 1'b0;
		dma_rnw = 1'b0;
		dma_len = '0;
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		// register write and read-back on both banks
		add_row(Z80_WR, 5'd16, 8'h00, 8'h00);
		add_row(Z80_WR, 5'd1, 8'h5a, 8'h00);
		add_row(Z80_RD, 5'd1, 8'h00, 8'h5a);
		add_row(Z80_WR, 5'd9, 8'hc3, 8'h00);
		add_row(Z80_RD, 5'd9, 8'h00, 8'hc3);
		add_row(Z80_WR, 5'd14, 8'h3c, 8'h00);
		add_row(Z80_RD, 5'd14, 8'h00, 8'h3c);
		// 16-bit word through the high latch
		add_row(Z80_WR, 5'd7, 8'h00, 8'h00);
		add_row(Z80_WR, 5'd16, 8'hbe, 8'h00);
		add_row(Z80_WR, 5'd0, 8'hef, 8'h00);
		add_row(Z80_WR, 5'd16, 8'h00, 8'h00);
		add_row(Z80_RD, 5'd0, 8'h00, 8'hef);
		add_row(Z80_RD, 5'd16, 8'h00, 8'hbe);
		// dma block out and back and again with a z80 access in between
		add_row(Z80_WR, 5'd7, 8'h00, 8'h00);
		add_row(DMA_WR, 5'd0, 8'h00, 8'h00);
		add_row(Z80_WR, 5'd7, 8'h00, 8'h00);
		add_row(DMA_RD, 5'd0, 8'h00, 8'h00);
		add_row(Z80_WR, 5'd7, 8'h00, 8'h00);
		add_row(CONC, 5'd10, 8'h77, 8'h77);
		blk_len = 4 + int'($urandom % 16);

		@(negedge clk);
		checks += 2;
		assert ({ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n} == 4'hf)
		else
		begin
			$display("** Error: {cs0_n,cs1_n,rd_n,wr_n} = %h, expected %h",
				{ide_cs0_n, ide_cs1_n, ide_rd_n, ide_wr_n}, 4'hf);
			errors++;
		end
		assert ({z80_wait, dma_busy} == 2'b00)
		else
		begin
			$display("** Error: {z80_wait,dma_busy} = %h, expected %h",
				{z80_wait, dma_busy}, 2'b00);
			errors++;
		end
		$display("reset state %s", (errors == 0) ? "ok" : "bad");

		for (int i = 0; i < rows.size(); i++)
		begin
			r = rows[i];
			err0 = errors;
			case (r.kind)
				Z80_WR:
					z80_io(1'b1, r.port, r.data, q, ok);
				Z80_RD:
				begin
					z80_io(1'b0, r.port, 8'h00, q, ok);
					if (ok)
						check_dout(q, r.want);
				end
				DMA_WR:
					dma_block(1'b0, blk_len);
				DMA_RD:
					dma_block(1'b1, blk_len);
				default:
				begin
					fork
						dma_block(1'b1, blk_len);
						begin
							repeat (4) @(posedge clk);
							z80_io(1'b1, r.port, r.data, q, ok);
							checks++;
							assert (dma_busy)
							else
							begin
								$display("z80 write finished outside the dma block");
								errors++;
							end
							z80_io(1'b0, r.port, 8'h00, q, ok);
							if (ok)
								check_dout(q, r.want);
						end
					join
				end
			endcase
			$display("row %0d %s port %h data %h len %0d %s", i, r.kind.name(), r.port,
				r.data, blk_len, (errors == err0) ? "ok" : "bad");
		end

		// pin protocol violations from the bound checker
		errors += dut0.chk0.fails;

		$display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
common/ide_pkg.sv
ide/ide_pio.sv
src/z80_ide_port.sv
src/ide_dma.sv
src/ide_top.sv
verification/hdd_model.sv
verification/ide_chk.sv
verification/ide_tb.sv
